// ==== cpu_pkg.sv ====
// MIPS subset core definitions
`default_nettype none

package cpu_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_COP0    = 6'h10,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        S_FETCH,
        S_DECODE,
        S_EXECUTE,
        S_MEMORY,
        S_WRITEBACK,
        S_TRAP
    } cpu_state_e;

    typedef enum logic [4:0] {
        CP0_COUNT   = 5'd9,
        CP0_COMPARE = 5'd11,
        CP0_STATUS  = 5'd12,
        CP0_CAUSE   = 5'd13,
        CP0_EPC     = 5'd14
    } cp0_reg_e;

    // writeback source select
    localparam logic [1:0] WB_ALU = 2'd0;
    localparam logic [1:0] WB_MEM = 2'd1;
    localparam logic [1:0] WB_CP0 = 2'd2;

    // next pc select, TARGET covers both branch and jump
    localparam logic [1:0] PC_SEQ    = 2'd0;
    localparam logic [1:0] PC_TARGET = 2'd1;
    localparam logic [1:0] PC_EPC    = 2'd2;
    localparam logic [1:0] PC_VECTOR = 2'd3;

endpackage

`default_nettype wire

// ==== cpu_alu.sv ====
// Subset ALU
`timescale 1ns/1ps
`default_nettype none

module cpu_alu import cpu_pkg::*; (
    input  wire logic [31:0] a_i,
    input  wire logic [31:0] b_i,
    input  alu_op_e          op_i,
    output logic [31:0]      result_o,
    output logic             zero_o
);

    always_comb begin
        case (op_i)
            ALU_SUB: result_o = a_i - b_i;
            ALU_AND: result_o = a_i & b_i;
            ALU_OR:  result_o = a_i | b_i;
            ALU_SLT: result_o = {31'd0, $signed(a_i) < $signed(b_i)};
            ALU_LUI: result_o = {b_i[15:0], 16'h0000}; // immediate to upper half
            default: result_o = a_i + b_i;
        endcase
    end

    assign zero_o = (result_o == 32'd0);

endmodule

`default_nettype wire

// ==== cpu_regfile.sv ====
// General purpose register file
`timescale 1ns/1ps
`default_nettype none

module cpu_regfile (
    input  wire logic        clk,
    input  wire logic        reset_i,
    input  wire logic [4:0]  raddr_a_i,
    input  wire logic [4:0]  raddr_b_i,
    output logic [31:0]      rdata_a_o,
    output logic [31:0]      rdata_b_o,
    input  wire logic        we_i,
    input  wire logic [4:0]  waddr_i,
    input  wire logic [31:0] wdata_i
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we_i && (waddr_i != 5'd0)) begin // $zero stays zero
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata_a_o = regs[raddr_a_i];
    assign rdata_b_o = regs[raddr_b_i];

endmodule

`default_nettype wire

// ==== cpu_control_fsm.sv ====
// Multicycle control FSM
`timescale 1ns/1ps
`default_nettype none

module cpu_control_fsm import cpu_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  opcode_e         opcode_i,
    input  funct_e          funct_i,
    input  wire logic [4:0] rs_field_i,
    input  wire logic       zero_i,
    input  wire logic       irq_pending_i,
    output cpu_state_e      state_o,
    output logic            pc_write_o,
    output logic            ir_write_o,
    output alu_op_e         alu_op_o,
    output logic            alu_src_imm_o,
    output logic            reg_write_o,
    output logic [1:0]      wb_sel_o,
    output logic            dst_rt_o,
    output logic [1:0]      pc_sel_o,
    output logic            mem_read_o,
    output logic            mem_write_o,
    output logic            cp0_write_o,
    output logic            take_irq_o,
    output logic            do_eret_o
);

    cpu_state_e state_q, state_d;
    logic is_mfc0, is_mtc0, is_eret;

    assign is_mfc0 = (opcode_i == OP_COP0) && (rs_field_i == 5'b00000);
    assign is_mtc0 = (opcode_i == OP_COP0) && (rs_field_i == 5'b00100);
    assign is_eret = (opcode_i == OP_COP0) && (rs_field_i == 5'b10000);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= S_FETCH;
        end else begin
            state_q <= state_d;
        end
    end

    assign state_o = state_q;

    // datapath steering from the instruction register alone
    always_comb begin
        alu_op_o      = ALU_ADD;
        alu_src_imm_o = 1'b1;
        wb_sel_o      = WB_ALU;
        dst_rt_o      = 1'b1;
        case (opcode_i)
            OP_SPECIAL: begin
                alu_src_imm_o = 1'b0;
                dst_rt_o      = 1'b0; // rd
                case (funct_i)
                    FN_SUBU: alu_op_o = ALU_SUB;
                    FN_AND:  alu_op_o = ALU_AND;
                    FN_OR:   alu_op_o = ALU_OR;
                    FN_SLT:  alu_op_o = ALU_SLT;
                    default: alu_op_o = ALU_ADD;
                endcase
            end
            OP_ORI:  alu_op_o = ALU_OR;
            OP_LUI:  alu_op_o = ALU_LUI;
            OP_LW:   wb_sel_o = WB_MEM;
            OP_COP0: wb_sel_o = WB_CP0;
            OP_BEQ, OP_BNE: begin
                alu_op_o      = ALU_SUB; // compare rs and rt
                alu_src_imm_o = 1'b0;
            end
            default: ;
        endcase
    end

    always_comb begin
        state_d     = state_q;
        pc_write_o  = 1'b0;
        ir_write_o  = 1'b0;
        reg_write_o = 1'b0;
        pc_sel_o    = PC_SEQ;
        mem_read_o  = 1'b0;
        mem_write_o = 1'b0;
        cp0_write_o = 1'b0;
        take_irq_o  = 1'b0;
        do_eret_o   = 1'b0;
        case (state_q)
            S_FETCH: state_d = irq_pending_i ? S_TRAP : S_DECODE;
            S_DECODE: begin
                ir_write_o = 1'b1;
                pc_write_o = 1'b1; // pc + 4
                state_d    = S_EXECUTE;
            end
            S_EXECUTE: begin
                state_d  = S_FETCH;
                pc_sel_o = PC_TARGET;
                case (opcode_i)
                    OP_SPECIAL, OP_ADDIU, OP_ORI, OP_LUI: state_d = S_WRITEBACK;
                    OP_LW, OP_SW: state_d = S_MEMORY;
                    OP_BEQ: pc_write_o = zero_i;
                    OP_BNE: pc_write_o = !zero_i;
                    OP_J:   pc_write_o = 1'b1;
                    OP_COP0: begin
                        cp0_write_o = is_mtc0;
                        do_eret_o   = is_eret;
                        pc_write_o  = is_eret;
                        pc_sel_o    = PC_EPC;
                        if (is_mfc0) begin
                            state_d = S_WRITEBACK;
                        end
                    end
                    default: ;
                endcase
            end
            S_MEMORY: begin
                mem_read_o  = (opcode_i == OP_LW);
                mem_write_o = (opcode_i == OP_SW);
                state_d     = (opcode_i == OP_LW) ? S_WRITEBACK : S_FETCH;
            end
            S_WRITEBACK: begin
                reg_write_o = 1'b1;
                state_d     = S_FETCH;
            end
            S_TRAP: begin
                take_irq_o = 1'b1;
                pc_write_o = 1'b1;
                pc_sel_o   = PC_VECTOR;
                state_d    = S_FETCH;
            end
            default: state_d = S_FETCH;
        endcase
    end

endmodule

`default_nettype wire

// ==== cpu_datapath.sv ====
// Multicycle datapath
`timescale 1ns/1ps
`default_nettype none

module cpu_datapath import cpu_pkg::*; #(
    parameter logic [31:0] RESET_PC   = 32'hBFC00000,
    parameter logic [31:0] EXC_VECTOR = 32'hBFC00380
) (
    input  wire logic        clk,
    input  wire logic        reset_i,
    input  wire logic        pc_write_i,
    input  wire logic        ir_write_i,
    input  alu_op_e          alu_op_i,
    input  wire logic        alu_src_imm_i,
    input  wire logic        reg_write_i,
    input  wire logic [1:0]  wb_sel_i,
    input  wire logic        dst_rt_i,
    input  wire logic [1:0]  pc_sel_i,
    input  wire logic [31:0] epc_i,
    input  wire logic [31:0] cp0_rdata_i,
    input  wire logic [31:0] inst_rdata_i,
    input  wire logic [31:0] data_rdata_i,
    output opcode_e          opcode_o,
    output funct_e           funct_o,
    output logic [4:0]       rs_field_o,
    output logic             zero_o,
    output logic [31:0]      pc_o,
    output logic [31:0]      inst_addr_o,
    output logic [31:0]      data_addr_o,
    output logic [31:0]      data_wdata_o,
    output cp0_reg_e         cp0_addr_o,
    output logic [31:0]      cp0_wdata_o,
    output logic [31:0]      wb_pc_o,
    output logic             wb_wen_o,
    output logic [4:0]       wb_wnum_o,
    output logic [31:0]      wb_wdata_o
);

    logic [31:0] pc_q, ir_q, ir_pc_q, a_q, b_q, alu_out_q;
    logic [31:0] rdata_a, rdata_b, imm_ext, alu_b, alu_result, target, wb_data;
    logic [4:0]  dst;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= RESET_PC;
        end else if (pc_write_i) begin
            case (pc_sel_i)
                PC_SEQ:    pc_q <= pc_q + 32'd4;
                PC_TARGET: pc_q <= target;
                PC_EPC:    pc_q <= epc_i;
                default:   pc_q <= EXC_VECTOR;
            endcase
        end
    end

    // operands are read while the fetched word is on the bus
    always_ff @(posedge clk) begin
        if (ir_write_i) begin
            ir_q    <= inst_rdata_i;
            ir_pc_q <= pc_q;
            a_q     <= rdata_a;
            b_q     <= rdata_b;
        end
        alu_out_q <= alu_result;
    end

    assign imm_ext = (opcode_o == OP_ORI) ? {16'h0000, ir_q[15:0]}
                                          : {{16{ir_q[15]}}, ir_q[15:0]};
    assign alu_b   = alu_src_imm_i ? imm_ext : b_q;

    // pc_q already holds pc + 4 in execute
    assign target = (opcode_o == OP_J) ? {pc_q[31:28], ir_q[25:0], 2'b00}
                                       : pc_q + {imm_ext[29:0], 2'b00};

    always_comb begin
        case (wb_sel_i)
            WB_MEM:  wb_data = data_rdata_i;
            WB_CP0:  wb_data = cp0_rdata_i;
            default: wb_data = alu_out_q;
        endcase
    end

    assign dst = dst_rt_i ? ir_q[20:16] : ir_q[15:11];

    cpu_regfile regfile_i (
        .clk       (clk),
        .reset_i   (reset_i),
        .raddr_a_i (inst_rdata_i[25:21]),
        .raddr_b_i (inst_rdata_i[20:16]),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b),
        .we_i      (reg_write_i),
        .waddr_i   (dst),
        .wdata_i   (wb_data)
    );

    cpu_alu alu_i (
        .a_i      (a_q),
        .b_i      (alu_b),
        .op_i     (alu_op_i),
        .result_o (alu_result),
        .zero_o   (zero_o)
    );

    assign opcode_o     = opcode_e'(ir_q[31:26]);
    assign funct_o      = funct_e'(ir_q[5:0]);
    assign rs_field_o   = ir_q[25:21];
    assign pc_o         = pc_q;
    assign inst_addr_o  = pc_q;
    assign data_addr_o  = alu_out_q;
    assign data_wdata_o = b_q;
    assign cp0_addr_o   = cp0_reg_e'(ir_q[15:11]);
    assign cp0_wdata_o  = b_q; // rt
    assign wb_pc_o      = ir_pc_q;
    assign wb_wen_o     = reg_write_i && (dst != 5'd0); // $zero writes are not reported
    assign wb_wnum_o    = dst;
    assign wb_wdata_o   = wb_data;

endmodule

`default_nettype wire

// ==== cp0_timer.sv ====
// Coprocessor 0 and timer
`timescale 1ns/1ps
`default_nettype none

module cp0_timer import cpu_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset_i,
    input  cp0_reg_e         addr_i,
    input  wire logic [31:0] wdata_i,
    input  wire logic        write_i,
    input  wire logic        take_irq_i,
    input  wire logic        do_eret_i,
    input  wire logic [31:0] pc_i,
    output logic [31:0]      rdata_o,
    output logic [31:0]      epc_o,
    output logic             irq_pending_o
);

    logic [31:0] count_q, compare_q, epc_q;
    logic        ip7_q, ie_q, exl_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            count_q <= 32'd0;
            ip7_q   <= 1'b0;
            ie_q    <= 1'b0;
            exl_q   <= 1'b0;
        end else begin
            count_q <= count_q + 32'd1;
            if (count_q == compare_q) begin
                ip7_q <= 1'b1;
            end
            if (write_i) begin
                case (addr_i)
                    CP0_COUNT:   count_q <= wdata_i;
                    CP0_COMPARE: ip7_q   <= 1'b0; // acknowledges the timer
                    CP0_STATUS: begin
                        ie_q  <= wdata_i[0];
                        exl_q <= wdata_i[1];
                    end
                    default: ;
                endcase
            end
            if (take_irq_i) begin
                exl_q <= 1'b1;
            end else if (do_eret_i) begin
                exl_q <= 1'b0;
            end
        end
    end

    // payload registers, written only by software or trap entry
    always_ff @(posedge clk) begin
        if (write_i && (addr_i == CP0_COMPARE)) begin
            compare_q <= wdata_i;
        end
        if (take_irq_i) begin
            epc_q <= pc_i;
        end else if (write_i && (addr_i == CP0_EPC)) begin
            epc_q <= wdata_i;
        end
    end

    always_comb begin
        case (addr_i)
            CP0_COUNT:   rdata_o = count_q;
            CP0_COMPARE: rdata_o = compare_q;
            CP0_STATUS:  rdata_o = {30'd0, exl_q, ie_q};
            CP0_CAUSE:   rdata_o = {16'd0, ip7_q, 15'd0};
            CP0_EPC:     rdata_o = epc_q;
            default:     rdata_o = 32'd0;
        endcase
    end

    assign epc_o         = epc_q;
    assign irq_pending_o = ip7_q && ie_q && !exl_q;

endmodule

`default_nettype wire

// ==== mycpu_top.sv ====
// Multicycle MIPS core top
`timescale 1ns/1ps
`default_nettype none

module mycpu_top import cpu_pkg::*; #(
    parameter logic [31:0] RESET_PC   = 32'hBFC00000,
    parameter logic [31:0] EXC_VECTOR = 32'hBFC00380
) (
    input  wire logic        clk,
    input  wire logic        reset_i,
    output logic             inst_sram_en_o,
    output logic [3:0]       inst_sram_wen_o,
    output logic [31:0]      inst_sram_addr_o,
    output logic [31:0]      inst_sram_wdata_o,
    input  wire logic [31:0] inst_sram_rdata_i,
    output logic             data_sram_en_o,
    output logic [3:0]       data_sram_wen_o,
    output logic [31:0]      data_sram_addr_o,
    output logic [31:0]      data_sram_wdata_o,
    input  wire logic [31:0] data_sram_rdata_i,
    output logic [31:0]      debug_wb_pc_o,
    output logic [3:0]       debug_wb_rf_wen_o,
    output logic [4:0]       debug_wb_rf_wnum_o,
    output logic [31:0]      debug_wb_rf_wdata_o
);

    cpu_state_e  state;
    opcode_e     opcode;
    funct_e      funct;
    alu_op_e     alu_op;
    cp0_reg_e    cp0_addr;
    logic [4:0]  rs_field;
    logic [1:0]  wb_sel, pc_sel;
    logic [31:0] pc, epc, cp0_rdata, cp0_wdata;
    logic        zero, irq_pending, pc_write, ir_write, alu_src_imm, reg_write, dst_rt;
    logic        mem_read, mem_write, cp0_write, take_irq, do_eret, wb_wen;

    cpu_control_fsm fsm_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .opcode_i      (opcode),
        .funct_i       (funct),
        .rs_field_i    (rs_field),
        .zero_i        (zero),
        .irq_pending_i (irq_pending),
        .state_o       (state),
        .pc_write_o    (pc_write),
        .ir_write_o    (ir_write),
        .alu_op_o      (alu_op),
        .alu_src_imm_o (alu_src_imm),
        .reg_write_o   (reg_write),
        .wb_sel_o      (wb_sel),
        .dst_rt_o      (dst_rt),
        .pc_sel_o      (pc_sel),
        .mem_read_o    (mem_read),
        .mem_write_o   (mem_write),
        .cp0_write_o   (cp0_write),
        .take_irq_o    (take_irq),
        .do_eret_o     (do_eret)
    );

    cpu_datapath #(
        .RESET_PC   (RESET_PC),
        .EXC_VECTOR (EXC_VECTOR)
    ) datapath_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .pc_write_i    (pc_write),
        .ir_write_i    (ir_write),
        .alu_op_i      (alu_op),
        .alu_src_imm_i (alu_src_imm),
        .reg_write_i   (reg_write),
        .wb_sel_i      (wb_sel),
        .dst_rt_i      (dst_rt),
        .pc_sel_i      (pc_sel),
        .epc_i         (epc),
        .cp0_rdata_i   (cp0_rdata),
        .inst_rdata_i  (inst_sram_rdata_i),
        .data_rdata_i  (data_sram_rdata_i),
        .opcode_o      (opcode),
        .funct_o       (funct),
        .rs_field_o    (rs_field),
        .zero_o        (zero),
        .pc_o          (pc),
        .inst_addr_o   (inst_sram_addr_o),
        .data_addr_o   (data_sram_addr_o),
        .data_wdata_o  (data_sram_wdata_o),
        .cp0_addr_o    (cp0_addr),
        .cp0_wdata_o   (cp0_wdata),
        .wb_pc_o       (debug_wb_pc_o),
        .wb_wen_o      (wb_wen),
        .wb_wnum_o     (debug_wb_rf_wnum_o),
        .wb_wdata_o    (debug_wb_rf_wdata_o)
    );

    cp0_timer cp0_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .addr_i        (cp0_addr),
        .wdata_i       (cp0_wdata),
        .write_i       (cp0_write),
        .take_irq_i    (take_irq),
        .do_eret_i     (do_eret),
        .pc_i          (pc),
        .rdata_o       (cp0_rdata),
        .epc_o         (epc),
        .irq_pending_o (irq_pending)
    );

    // no fetch in the cycle that diverts to the trap state
    assign inst_sram_en_o    = (state == S_FETCH) && !irq_pending && !reset_i;
    assign inst_sram_wen_o   = 4'b0000;
    assign inst_sram_wdata_o = 32'd0;

    assign data_sram_en_o    = mem_read || mem_write;
    assign data_sram_wen_o   = mem_write ? 4'b1111 : 4'b0000;

    assign debug_wb_rf_wen_o = {4{wb_wen}};

endmodule

`default_nettype wire

// ==== mycpu_properties.sv ====
// SRAM and debug port properties
`timescale 1ns/1ps
`default_nettype none

module mycpu_properties (
    input wire logic        clk,
    input wire logic        reset_i,
    input wire logic        inst_sram_en_i,
    input wire logic [3:0]  inst_sram_wen_i,
    input wire logic        data_sram_en_i,
    input wire logic [31:0] data_sram_addr_i,
    input wire logic [3:0]  debug_wb_rf_wen_i,
    input wire logic [4:0]  debug_wb_rf_wnum_i
);

    inst_never_written: assert property (@(posedge clk) inst_sram_wen_i == 4'b0000)
        else $error("instruction port write enable set");

    quiet_in_reset: assert property (@(posedge clk) reset_i |-> !inst_sram_en_i && !data_sram_en_i)
        else $error("SRAM enable during reset");

    one_port_at_a_time: assert property (@(posedge clk) disable iff (reset_i)
        !(inst_sram_en_i && data_sram_en_i))
        else $error("both SRAM enables high");

    word_aligned: assert property (@(posedge clk) disable iff (reset_i)
        data_sram_en_i |-> data_sram_addr_i[1:0] == 2'b00)
        else $error("unaligned data address");

    no_zero_write: assert property (@(posedge clk) disable iff (reset_i)
        debug_wb_rf_wen_i != 4'b0000 |-> debug_wb_rf_wnum_i != 5'd0)
        else $error("writeback to register zero");

endmodule

bind mycpu_top mycpu_properties props_i (
    .clk                (clk),
    .reset_i            (reset_i),
    .inst_sram_en_i     (inst_sram_en_o),
    .inst_sram_wen_i    (inst_sram_wen_o),
    .data_sram_en_i     (data_sram_en_o),
    .data_sram_addr_i   (data_sram_addr_o),
    .debug_wb_rf_wen_i  (debug_wb_rf_wen_o),
    .debug_wb_rf_wnum_i (debug_wb_rf_wnum_o)
);

`default_nettype wire

// ==== tb_mycpu.sv ====
// Multicycle core testbench
`timescale 1ns/1ps
`default_nettype none

module tb_mycpu import cpu_pkg::*; ();

    localparam logic [31:0] RESET_PC   = 32'hBFC00000;
    localparam logic [31:0] EXC_VECTOR = 32'hBFC00380;
    localparam int          LIMIT_CYCLES = 38 * 6 + 60 + 120; // program, timer wait, margin

    logic        clk, reset_i;
    logic        inst_en, data_en;
    logic [3:0]  inst_wen, data_wen, dbg_wen;
    logic [31:0] inst_addr, inst_wdata, inst_rdata, data_addr, data_wdata, data_rdata;
    logic [31:0] dbg_pc, dbg_wdata;
    logic [4:0]  dbg_wnum;

    logic [31:0] rom [256];
    logic [31:0] ram [64];
    // reference machine state
    logic [31:0] regs [32];
    logic [31:0] mram [64];
    logic [31:0] m_pc, m_epc, exp_pc, exp_val, st_addr, st_data;
    logic [4:0]  exp_num;
    logic        m_ie, m_exl, m_armed, prog_done, st_pending, fetch_seen;
    int          errors, wb_count, passed, failed, mark;

    mycpu_top dut_i (
        .clk (clk), .reset_i (reset_i),
        .inst_sram_en_o (inst_en), .inst_sram_wen_o (inst_wen),
        .inst_sram_addr_o (inst_addr), .inst_sram_wdata_o (inst_wdata),
        .inst_sram_rdata_i (inst_rdata),
        .data_sram_en_o (data_en), .data_sram_wen_o (data_wen),
        .data_sram_addr_o (data_addr), .data_sram_wdata_o (data_wdata),
        .data_sram_rdata_i (data_rdata),
        .debug_wb_pc_o (dbg_pc), .debug_wb_rf_wen_o (dbg_wen),
        .debug_wb_rf_wnum_o (dbg_wnum), .debug_wb_rf_wdata_o (dbg_wdata)
    );

    function automatic logic [31:0] r_op(funct_e fn, int rd, int rs, int rt);
        return {OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_op(opcode_e op, int rt, int rs, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic logic [31:0] cop0(int sel, int rt, int rd); // sel 0 mfc0, 4 mtc0, 16 eret
        return {OP_COP0, 5'(sel), 5'(rt), 5'(rd), 5'd0, (sel == 16) ? 6'h18 : 6'h00};
    endfunction

    task automatic value_error(string name, logic [31:0] got, logic [31:0] exp);
        $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        errors++;
    endtask

    task automatic plain_error(string what);
        $display("at %0t: %s", $time, what);
        errors++;
    endtask

    task automatic write_reg(int num, logic [31:0] val);
        exp_pc  = m_pc;
        exp_num = 5'(num);
        exp_val = val;
        if (num != 0) regs[num] = val;
    endtask

    // runs the reference machine up to its next register write
    task automatic advance_model();
        logic [31:0] ir, a, b, imm_s, nxt, res;
        logic        wrote, taken;
        wrote = 1'b0;
        while (!wrote && !prog_done) begin
            ir    = rom[m_pc[9:2]];
            a     = regs[ir[25:21]];
            b     = regs[ir[20:16]];
            imm_s = {{16{ir[15]}}, ir[15:0]};
            nxt   = m_pc + 32'd4;
            wrote = 1'b1;
            case (ir[31:26])
                OP_SPECIAL: begin
                    case (ir[5:0])
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: res = a + b;
                    endcase
                    write_reg(ir[15:11], res);
                end
                OP_ADDIU: write_reg(ir[20:16], a + imm_s);
                OP_ORI:   write_reg(ir[20:16], a | {16'h0000, ir[15:0]});
                OP_LUI:   write_reg(ir[20:16], {ir[15:0], 16'h0000});
                OP_LW:    write_reg(ir[20:16], mram[6'((a + imm_s) >> 2)]);
                OP_SW: begin
                    mram[6'((a + imm_s) >> 2)] = b;
                    st_addr    = a + imm_s;
                    st_data    = b;
                    st_pending = 1'b1;
                    wrote      = 1'b0;
                end
                OP_BEQ, OP_BNE: begin
                    taken = (a == b) ^ (ir[31:26] == OP_BNE);
                    wrote = 1'b0;
                    if (taken && (nxt + {imm_s[29:0], 2'b00} == m_pc)) begin
                        if (m_ie && !m_exl && m_armed) begin // spin ends in the timer trap
                            m_epc   = m_pc;
                            m_exl   = 1'b1;
                            m_armed = 1'b0;
                            nxt     = EXC_VECTOR;
                        end else begin
                            prog_done = 1'b1;
                        end
                    end else if (taken) begin
                        nxt = nxt + {imm_s[29:0], 2'b00};
                    end
                end
                OP_J: begin
                    nxt   = {nxt[31:28], ir[25:0], 2'b00};
                    wrote = 1'b0;
                end
                default: begin // cop0
                    wrote = (ir[25:21] == 5'd0);
                    if (wrote) begin
                        write_reg(ir[20:16], (ir[15:11] == CP0_EPC) ? m_epc : {31'd0, m_ie});
                    end else if (ir[25:21] == 5'd16) begin
                        nxt   = m_epc;
                        m_exl = 1'b0;
                    end else if (ir[15:11] == CP0_STATUS) begin
                        m_ie  = b[0];
                        m_exl = b[1];
                    end else if (ir[15:11] == CP0_COMPARE) begin
                        m_armed = (b < 32'd1000); // far values never match within the run
                    end
                end
            endcase
            if (wrote && (exp_num == 5'd0)) begin
                wrote = 1'b0; // writes to $zero leave no writeback
            end
            m_pc = nxt;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // instruction ROM and data RAM, one cycle read latency
    always @(posedge clk) begin
        logic        i_en, d_en;
        logic [3:0]  d_wen;
        logic [31:0] i_addr, d_addr, d_wdata;
        i_en = inst_en;
        i_addr = inst_addr;
        d_en = data_en;
        d_wen = data_wen;
        d_addr = data_addr;
        d_wdata = data_wdata;
        #1;
        if (i_en) inst_rdata = rom[i_addr[9:2]];
        if (d_en && d_wen == 4'b1111) ram[d_addr[7:2]] = d_wdata;
        else if (d_en) data_rdata = ram[d_addr[7:2]];
    end

    always @(posedge clk) begin
        if (reset_i) begin
            assert (!inst_en && !data_en && (dbg_wen == 4'b0000))
                else plain_error("enable high during reset");
        end else begin
            assert (inst_wdata == 32'd0) else value_error("inst_sram_wdata", inst_wdata, 32'd0);
            if (!fetch_seen) begin // first cycle out of reset
                fetch_seen = 1'b1;
                assert (inst_en) else plain_error("no fetch in the first cycle after reset");
                assert (inst_addr == RESET_PC)
                    else value_error("inst_sram_addr", inst_addr, RESET_PC);
            end
            if (data_en && data_wen != 4'b0000) begin
                assert (st_pending) else plain_error("store issued where the program has none");
                assert (data_wen == 4'b1111)
                    else value_error("data_sram_wen", 32'(data_wen), 32'hf);
                assert (data_addr == st_addr)
                    else value_error("data_sram_addr", data_addr, st_addr);
                assert (data_wdata == st_data)
                    else value_error("data_sram_wdata", data_wdata, st_data);
                st_pending = 1'b0;
            end
            if (dbg_wen != 4'b0000) begin
                assert (!prog_done) else plain_error("writeback after the program reached its end");
                assert (dbg_pc == exp_pc) else value_error("debug_wb_pc", dbg_pc, exp_pc);
                assert (dbg_wnum == exp_num)
                    else value_error("debug_wb_rf_wnum", 32'(dbg_wnum), 32'(exp_num));
                assert (dbg_wdata == exp_val)
                    else value_error("debug_wb_rf_wdata", dbg_wdata, exp_val);
                wb_count++;
                advance_model();
            end
        end
    end

    task automatic finish_test(string name);
        if (errors == mark) passed++;
        else failed++;
        $display("test %s: %s", name, (errors == mark) ? "ok" : "errors");
        mark = errors;
    endtask

    initial begin
        #(LIMIT_CYCLES * 100);
        $display("watchdog expired before the program finished");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        reset_i = 1'b1;
        inst_rdata = 32'd0;
        data_rdata = 32'd0;
        {errors, wb_count, passed, failed, mark} = '0;
        {m_ie, m_exl, m_armed, prog_done, st_pending, fetch_seen} = '0;
        foreach (rom[i]) rom[i] = 32'd0;
        foreach (ram[i]) begin
            ram[i]  = 32'hd00d_0000 ^ (i * 32'h0101_0101);
            mram[i] = ram[i];
        end
        foreach (regs[i]) regs[i] = 32'd0;
        rom[0]  = i_op(OP_LUI, 1, 0, 16'h1234);
        rom[1]  = i_op(OP_ORI, 1, 1, 16'h5678);
        rom[2]  = i_op(OP_ADDIU, 2, 0, -5);
        rom[3]  = i_op(OP_ADDIU, 3, 0, 3);
        rom[4]  = r_op(FN_SLT, 4, 2, 3);
        rom[5]  = r_op(FN_SLT, 5, 3, 2);
        rom[6]  = r_op(FN_ADDU, 6, 1, 2);
        rom[7]  = r_op(FN_SUBU, 7, 3, 2);
        rom[8]  = r_op(FN_AND, 8, 1, 2);
        rom[9]  = r_op(FN_OR, 9, 3, 2);
        rom[10] = i_op(OP_ADDIU, 0, 3, 7);  // $zero must ignore this
        rom[11] = r_op(FN_ADDU, 19, 0, 3);
        rom[12] = i_op(OP_SW, 1, 0, 8);
        rom[13] = i_op(OP_LW, 10, 0, 8);
        rom[14] = i_op(OP_BEQ, 1, 10, 1);  // taken
        rom[15] = i_op(OP_ADDIU, 11, 0, 1);
        rom[16] = i_op(OP_BNE, 5, 4, 1);   // taken
        rom[17] = i_op(OP_ADDIU, 11, 0, 2);
        rom[18] = i_op(OP_BEQ, 5, 4, 1);
        rom[19] = i_op(OP_ADDIU, 12, 0, 3);
        rom[20] = i_op(OP_BNE, 1, 10, 1);
        rom[21] = i_op(OP_ADDIU, 13, 0, 4);
        rom[22] = {OP_J, 26'((RESET_PC + 32'd96) >> 2)};
        rom[23] = i_op(OP_ADDIU, 14, 0, 5);
        rom[24] = i_op(OP_LUI, 27, 0, 16'h7fff);
        rom[25] = cop0(4, 0, CP0_COUNT);
        rom[26] = i_op(OP_ADDIU, 15, 0, 40);
        rom[27] = cop0(4, 15, CP0_COMPARE);
        rom[28] = i_op(OP_ADDIU, 16, 0, 1);
        rom[29] = cop0(4, 16, CP0_STATUS);
        rom[30] = i_op(OP_BEQ, 0, 17, -1); // wait for the handler flag
        rom[31] = i_op(OP_ADDIU, 18, 0, 9);
        rom[32] = i_op(OP_ADDIU, 18, 18, 1);
        rom[33] = i_op(OP_BEQ, 0, 0, -1);
        rom[8'hE0] = cop0(0, 26, CP0_EPC);
        rom[8'hE1] = cop0(4, 27, CP0_COMPARE);
        rom[8'hE2] = i_op(OP_ADDIU, 17, 0, 1);
        rom[8'hE3] = cop0(16, 0, 0);
        m_pc = RESET_PC;
        advance_model();
        repeat (2) @(posedge clk);
        #1 reset_i = 1'b0;
        wait (fetch_seen);
        finish_test("reset");
        wait (wb_count >= 11);
        finish_test("register_and_immediate_ops");
        wait (wb_count >= 12);
        finish_test("store_load");
        wait (wb_count >= 15);
        finish_test("branches_and_jump");
        wait (wb_count >= 21);
        repeat (60) @(posedge clk); // a second trap would show up here
        assert (wb_count == 21) else plain_error("extra writebacks after the interrupt test");
        finish_test("timer_interrupt");
        $display("%0d tests passed, %0d failed, %0d errors", passed, failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
cpu_pkg.sv
cpu_alu.sv
cpu_regfile.sv
cpu_control_fsm.sv
cpu_datapath.sv
cp0_timer.sv
mycpu_top.sv
mycpu_properties.sv
tb_mycpu.sv

// ==== run.sh ====
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_mycpu -o sim_tb_mycpu
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb_mycpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
exit 0
